// File: common/decode_pkg.sv
package decode_pkg;

    localparam int XLEN       = 32;    // Data path width
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam reg_addr_t REG_ZERO = 5'd0;    // x0, no writeback

    // One-hot functional unit select
    typedef enum logic [2:0] {
        FU_NONE = 3'b000,
        FU_ALU  = 3'b001,
        FU_CFU  = 3'b010,
        FU_LSU  = 3'b100
    } fu_e;

    typedef enum logic [4:0] {
        UOP_NONE = 5'd0,
        ALU_ADD  = 5'd1,
        ALU_SUB  = 5'd2,
        ALU_AND  = 5'd3,
        ALU_OR   = 5'd4,
        ALU_XOR  = 5'd5,
        ALU_SLT  = 5'd6,
        ALU_SLTU = 5'd7,
        ALU_SLL  = 5'd8,
        ALU_SRL  = 5'd9,
        ALU_SRA  = 5'd10,
        CFU_BEQ  = 5'd11,
        CFU_BNE  = 5'd12,
        CFU_BLT  = 5'd13,
        CFU_BGE  = 5'd14,
        CFU_BLTU = 5'd15,
        CFU_BGEU = 5'd16,
        CFU_JALI = 5'd17,
        CFU_JALR = 5'd18
    } uop_e;

    // LSU micro-ops are assembled from these fields
    localparam int         LSU_LOAD   = 4;
    localparam int         LSU_STORE  = 3;
    localparam int         LSU_SIGNED = 0;
    localparam logic [1:0] LSU_BYTE   = 2'b01;
    localparam logic [1:0] LSU_HALF   = 2'b10;
    localparam logic [1:0] LSU_WORD   = 2'b11;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHAMT
    } imm_fmt_e;

    typedef enum logic [4:0] {
        TRAP_NONE    = 5'd0,
        TRAP_IACCESS = 5'd1,
        TRAP_IOPCODE = 5'd2
    } trap_cause_e;

endpackage

// File: decode/instr_classifier.sv
`timescale 1ns/1ps

module instr_classifier (
    input  decode_pkg::word_t     i_instr,
    input  logic                  i_fetch_error,
    output decode_pkg::reg_addr_t o_rs1_addr,
    output decode_pkg::reg_addr_t o_rs2_addr,
    output decode_pkg::reg_addr_t o_rd,
    output decode_pkg::fu_e       o_fu,
    output decode_pkg::uop_e      o_uop,
    output decode_pkg::imm_fmt_e  o_imm_fmt,
    output logic                  o_trap,
    output logic                  o_opra_rs1,
    output logic                  o_opra_pcim,
    output logic                  o_oprb_rs2,
    output logic                  o_oprb_imm,
    output logic                  o_oprc_rs2,
    output logic                  o_oprc_pcim
);
    import decode_pkg::*;

    // Major opcodes, low two bits included
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OPIMM  = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        is_op;
    logic        is_opimm;
    logic        is_lui;
    logic        is_auipc;
    logic        is_load;
    logic        is_store;
    logic        is_branch;
    logic        is_jal;
    logic        is_jalr;
    logic        shift_op;
    logic        f7_zero;
    logic        f7_alt;
    logic        legal;
    logic        trap;
    trap_cause_e cause;
    uop_e        alu_uop;
    uop_e        br_uop;
    logic [1:0]  lsu_width;
    logic [4:0]  lsu_bits;

    assign funct3    = i_instr[14:12];
    assign funct7    = i_instr[31:25];
    assign is_op     = (i_instr[6:0] == OPC_OP);
    assign is_opimm  = (i_instr[6:0] == OPC_OPIMM);
    assign is_lui    = (i_instr[6:0] == OPC_LUI);
    assign is_auipc  = (i_instr[6:0] == OPC_AUIPC);
    assign is_load   = (i_instr[6:0] == OPC_LOAD);
    assign is_store  = (i_instr[6:0] == OPC_STORE);
    assign is_branch = (i_instr[6:0] == OPC_BRANCH);
    assign is_jal    = (i_instr[6:0] == OPC_JAL);
    assign is_jalr   = (i_instr[6:0] == OPC_JALR);

    assign shift_op = (funct3[1:0] == 2'b01);    // SLL, SRL, SRA
    assign f7_zero  = (funct7 == 7'b0000000);
    assign f7_alt   = (funct7 == 7'b0100000);    // SUB and SRA

    // -------------------------------------------------------------------------
    // Legal encodings and trap

    assign legal =
        (is_op     && (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)))) ||
        (is_opimm  && (!shift_op || f7_zero || (f7_alt && funct3[2]))) ||
        (is_load   && funct3[1:0] != 2'b11 && funct3 != 3'b110) ||
        (is_store  && !funct3[2] && funct3[1:0] != 2'b11) ||
        (is_branch && funct3[2:1] != 2'b01) ||
        (is_jalr   && funct3 == 3'b000) ||
        is_lui || is_auipc || is_jal;

    assign trap   = i_fetch_error || !legal;
    assign cause  = legal ? TRAP_IACCESS : TRAP_IOPCODE;
    assign o_trap = trap;

    // -------------------------------------------------------------------------
    // Micro-op selection

    always_comb begin
        case (funct3)
            3'b000:  alu_uop = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_uop = ALU_SLL;
            3'b010:  alu_uop = ALU_SLT;
            3'b011:  alu_uop = ALU_SLTU;
            3'b100:  alu_uop = ALU_XOR;
            3'b101:  alu_uop = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_uop = ALU_OR;
            default: alu_uop = ALU_AND;
        endcase
        case (funct3)
            3'b000:  br_uop = CFU_BEQ;
            3'b001:  br_uop = CFU_BNE;
            3'b100:  br_uop = CFU_BLT;
            3'b101:  br_uop = CFU_BGE;
            3'b110:  br_uop = CFU_BLTU;
            default: br_uop = CFU_BGEU;
        endcase
        case (funct3[1:0])
            2'b00:   lsu_width = LSU_BYTE;
            2'b01:   lsu_width = LSU_HALF;
            default: lsu_width = LSU_WORD;
        endcase
    end

    assign lsu_bits[LSU_LOAD]   = is_load;
    assign lsu_bits[LSU_STORE]  = is_store;
    assign lsu_bits[2:1]        = lsu_width;
    assign lsu_bits[LSU_SIGNED] = is_load && !funct3[2];    // LB and LH

    always_comb begin
        o_fu      = FU_NONE;
        o_uop     = UOP_NONE;
        o_imm_fmt = IMM_NONE;
        if (trap) begin
            o_fu = FU_NONE;    // Trap slot carries no unit
        end else if (is_op || is_opimm) begin
            o_fu      = FU_ALU;
            o_uop     = alu_uop;
            o_imm_fmt = is_op ? IMM_NONE : (shift_op ? IMM_SHAMT : IMM_I);
        end else if (is_lui || is_auipc) begin
            o_fu      = FU_ALU;
            o_uop     = is_lui ? ALU_OR : ALU_ADD;    // LUI ORs the immediate into zero
            o_imm_fmt = IMM_U;
        end else if (is_load || is_store) begin
            o_fu      = FU_LSU;
            o_uop     = uop_e'(lsu_bits);
            o_imm_fmt = is_store ? IMM_S : IMM_I;
        end else if (is_branch) begin
            o_fu      = FU_CFU;
            o_uop     = br_uop;
            o_imm_fmt = IMM_B;
        end else begin
            o_fu      = FU_CFU;
            o_uop     = is_jal ? CFU_JALI : CFU_JALR;
            o_imm_fmt = is_jal ? IMM_J : IMM_I;
        end
    end

    // -------------------------------------------------------------------------
    // Register addresses and operand sources

    assign o_rs1_addr = i_instr[19:15];
    assign o_rs2_addr = i_instr[24:20];

    assign o_rd = trap                    ? reg_addr_t'(cause) :
                  (is_store || is_branch) ? REG_ZERO :
                                            i_instr[11:7];

    assign o_opra_rs1  = !trap && (is_op || is_opimm || is_load || is_store ||
                                   is_branch || is_jalr);
    assign o_opra_pcim = !trap && is_auipc;
    assign o_oprb_rs2  = !trap && (is_op || is_branch);
    assign o_oprb_imm  = !trap && (is_opimm || is_lui || is_load || is_store || is_jalr);
    assign o_oprc_rs2  = !trap && is_store;           // Store data
    assign o_oprc_pcim = !trap && (is_branch || is_jal);    // Branch or jump target

endmodule

// File: decode/imm_builder.sv
`timescale 1ns/1ps

module imm_builder (
    input  decode_pkg::word_t    i_instr,
    input  decode_pkg::imm_fmt_e i_imm_fmt,
    output decode_pkg::word_t    o_imm,
    output decode_pkg::word_t    o_pc_imm
);
    import decode_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    word_t imm_shamt;
    logic  pc_rel;

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    assign imm_shamt = {{(XLEN-5){1'b0}}, i_instr[24:20]};    // Shift amount only

    always_comb begin
        case (i_imm_fmt)
            IMM_I:     o_imm = imm_i;
            IMM_S:     o_imm = imm_s;
            IMM_B:     o_imm = imm_b;
            IMM_U:     o_imm = imm_u;
            IMM_J:     o_imm = imm_j;
            IMM_SHAMT: o_imm = imm_shamt;
            default:   o_imm = '0;
        endcase
    end

    // Only these formats feed the PC adder
    assign pc_rel   = (i_imm_fmt == IMM_B) || (i_imm_fmt == IMM_J) || (i_imm_fmt == IMM_U);
    assign o_pc_imm = pc_rel ? o_imm : '0;

endmodule

// File: decode/operand_select.sv
`timescale 1ns/1ps

module operand_select #(
    parameter decode_pkg::word_t PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              i_accept,
    input  logic              i_cf_req,
    input  logic              i_cf_ack,
    input  decode_pkg::word_t i_cf_target,
    input  decode_pkg::word_t i_rs1_rdata,
    input  decode_pkg::word_t i_rs2_rdata,
    input  decode_pkg::word_t i_imm,
    input  decode_pkg::word_t i_pc_imm,
    input  logic              i_opra_rs1,
    input  logic              i_opra_pcim,
    input  logic              i_oprb_rs2,
    input  logic              i_oprb_imm,
    input  logic              i_oprc_rs2,
    input  logic              i_oprc_pcim,
    output decode_pkg::word_t o_opr_a,
    output decode_pkg::word_t o_opr_b,
    output decode_pkg::word_t o_opr_c,
    output logic              o_ld_a,
    output logic              o_ld_b,
    output logic              o_ld_c
);
    import decode_pkg::*;

    word_t pc_q;           // Address of the word now in decode
    word_t pc_plus_imm;
    logic  opra_zero;
    logic  oprb_zero;

    // -------------------------------------------------------------------------
    // Program counter

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= PC_RESET_VALUE;
        end else if (i_cf_req && i_cf_ack) begin
            pc_q <= i_cf_target;           // Redirect wins over advance
        end else if (i_accept) begin
            pc_q <= pc_q + word_t'(4);
        end
    end

    assign pc_plus_imm = pc_q + i_pc_imm;

    // -------------------------------------------------------------------------
    // Operand multiplexing

    // LUI is the only word with an immediate B and no A source
    assign opra_zero = !(i_opra_rs1 || i_opra_pcim) && i_oprb_imm;

    // AUIPC and JAL use PC+imm with nothing in B
    assign oprb_zero = !(i_oprb_rs2 || i_oprb_imm) && (i_opra_pcim || i_oprc_pcim);

    assign o_opr_a = {XLEN{i_opra_rs1}}  & i_rs1_rdata |
                     {XLEN{i_opra_pcim}} & pc_plus_imm;

    assign o_opr_b = {XLEN{i_oprb_rs2}}  & i_rs2_rdata |
                     {XLEN{i_oprb_imm}}  & i_imm;

    assign o_opr_c = {XLEN{i_oprc_rs2}}  & i_rs2_rdata |
                     {XLEN{i_oprc_pcim}} & pc_plus_imm;

    assign o_ld_a = i_opra_rs1 || i_opra_pcim || opra_zero;
    assign o_ld_b = i_oprb_rs2 || i_oprb_imm  || oprb_zero;
    assign o_ld_c = i_oprc_rs2 || i_oprc_pcim;

endmodule

// File: logic/stage_register.sv
`timescale 1ns/1ps

module stage_register (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  i_valid,
    input  logic                  i_flush,
    input  logic                  i_busy,
    input  logic                  i_ld_a,
    input  logic                  i_ld_b,
    input  logic                  i_ld_c,
    input  decode_pkg::reg_addr_t i_rd,
    input  decode_pkg::fu_e       i_fu,
    input  decode_pkg::uop_e      i_uop,
    input  logic                  i_trap,
    input  decode_pkg::word_t     i_instr,
    input  decode_pkg::word_t     i_opr_a,
    input  decode_pkg::word_t     i_opr_b,
    input  decode_pkg::word_t     i_opr_c,
    output logic                  o_valid,
    output logic                  o_busy,
    output logic                  o_accept,
    output decode_pkg::reg_addr_t o_rd,
    output decode_pkg::fu_e       o_fu,
    output decode_pkg::uop_e      o_uop,
    output logic                  o_trap,
    output decode_pkg::word_t     o_instr,
    output decode_pkg::word_t     o_opr_a,
    output decode_pkg::word_t     o_opr_b,
    output decode_pkg::word_t     o_opr_c
);
    import decode_pkg::*;

    logic [2:0] ld_en;
    word_t      opr_d [3];
    word_t      opr_q [3];

    assign o_busy   = o_valid && i_busy;              // No skid buffer
    assign o_accept = i_valid && !o_busy && !i_flush;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;
            o_fu    <= FU_NONE;
            o_uop   <= UOP_NONE;
            o_trap  <= 1'b0;
        end else if (o_accept) begin
            o_valid <= 1'b1;
            o_fu    <= i_fu;
            o_uop   <= i_uop;
            o_trap  <= i_trap;
        end else if (!i_busy) begin
            o_valid <= 1'b0;                          // Consumed, nothing new
        end
    end

    always_ff @(posedge g_clk) begin
        if (o_accept) begin
            o_rd    <= i_rd;
            o_instr <= i_instr;
        end
    end

    // -------------------------------------------------------------------------
    // Operand registers, each with its own load enable

    assign ld_en    = {i_ld_c, i_ld_b, i_ld_a};
    assign opr_d[0] = i_opr_a;
    assign opr_d[1] = i_opr_b;
    assign opr_d[2] = i_opr_c;

    always_ff @(posedge g_clk) begin
        for (int i = 0; i < 3; i++) begin
            if (i_flush) begin
                opr_q[i] <= '0;
            end else if (o_accept && ld_en[i]) begin
                opr_q[i] <= opr_d[i];
            end
        end
    end

    assign o_opr_a = opr_q[0];
    assign o_opr_b = opr_q[1];
    assign o_opr_c = opr_q[2];

endmodule

// File: decode/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
    parameter decode_pkg::word_t PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  i_s1_valid,
    input  decode_pkg::word_t     i_s1_data,
    input  logic                  i_s1_error,
    input  logic                  i_flush,
    input  decode_pkg::word_t     i_rs1_rdata,
    input  decode_pkg::word_t     i_rs2_rdata,
    input  logic                  i_cf_req,
    input  decode_pkg::word_t     i_cf_target,
    input  logic                  i_cf_ack,
    input  logic                  i_s2_busy,
    output logic                  o_s1_busy,
    output decode_pkg::reg_addr_t o_rs1_addr,
    output decode_pkg::reg_addr_t o_rs2_addr,
    output logic                  o_s2_valid,
    output decode_pkg::reg_addr_t o_s2_rd,
    output decode_pkg::fu_e       o_s2_fu,
    output decode_pkg::uop_e      o_s2_uop,
    output logic                  o_s2_trap,
    output decode_pkg::word_t     o_s2_opr_a,
    output decode_pkg::word_t     o_s2_opr_b,
    output decode_pkg::word_t     o_s2_opr_c,
    output decode_pkg::word_t     o_s2_instr
);
    import decode_pkg::*;

    reg_addr_t dec_rd;
    fu_e       dec_fu;
    uop_e      dec_uop;
    imm_fmt_e  dec_imm_fmt;
    logic      dec_trap;
    logic      opra_rs1;
    logic      opra_pcim;
    logic      oprb_rs2;
    logic      oprb_imm;
    logic      oprc_rs2;
    logic      oprc_pcim;
    word_t     imm;
    word_t     pc_imm;
    word_t     opr_a;
    word_t     opr_b;
    word_t     opr_c;
    logic      ld_a;
    logic      ld_b;
    logic      ld_c;
    logic      accept;      // Word taken this edge

    // -------------------------------------------------------------------------
    // Field classification

    instr_classifier u_classifier (
        .i_instr       (i_s1_data),
        .i_fetch_error (i_s1_error),
        .o_rs1_addr    (o_rs1_addr),
        .o_rs2_addr    (o_rs2_addr),
        .o_rd          (dec_rd),
        .o_fu          (dec_fu),
        .o_uop         (dec_uop),
        .o_imm_fmt     (dec_imm_fmt),
        .o_trap        (dec_trap),
        .o_opra_rs1    (opra_rs1),
        .o_opra_pcim   (opra_pcim),
        .o_oprb_rs2    (oprb_rs2),
        .o_oprb_imm    (oprb_imm),
        .o_oprc_rs2    (oprc_rs2),
        .o_oprc_pcim   (oprc_pcim)
    );

    // -------------------------------------------------------------------------
    // Immediate, PC and operands

    imm_builder u_imm_builder (
        .i_instr   (i_s1_data),
        .i_imm_fmt (dec_imm_fmt),
        .o_imm     (imm),
        .o_pc_imm  (pc_imm)
    );

    operand_select #(
        .PC_RESET_VALUE (PC_RESET_VALUE)
    ) u_operand_select (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_accept    (accept),
        .i_cf_req    (i_cf_req),
        .i_cf_ack    (i_cf_ack),
        .i_cf_target (i_cf_target),
        .i_rs1_rdata (i_rs1_rdata),
        .i_rs2_rdata (i_rs2_rdata),
        .i_imm       (imm),
        .i_pc_imm    (pc_imm),
        .i_opra_rs1  (opra_rs1),
        .i_opra_pcim (opra_pcim),
        .i_oprb_rs2  (oprb_rs2),
        .i_oprb_imm  (oprb_imm),
        .i_oprc_rs2  (oprc_rs2),
        .i_oprc_pcim (oprc_pcim),
        .o_opr_a     (opr_a),
        .o_opr_b     (opr_b),
        .o_opr_c     (opr_c),
        .o_ld_a      (ld_a),
        .o_ld_b      (ld_b),
        .o_ld_c      (ld_c)
    );

    // -------------------------------------------------------------------------
    // Stage register towards execute

    stage_register u_stage_register (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_valid  (i_s1_valid),
        .i_flush  (i_flush),
        .i_busy   (i_s2_busy),
        .i_ld_a   (ld_a),
        .i_ld_b   (ld_b),
        .i_ld_c   (ld_c),
        .i_rd     (dec_rd),
        .i_fu     (dec_fu),
        .i_uop    (dec_uop),
        .i_trap   (dec_trap),
        .i_instr  (i_s1_data),
        .i_opr_a  (opr_a),
        .i_opr_b  (opr_b),
        .i_opr_c  (opr_c),
        .o_valid  (o_s2_valid),
        .o_busy   (o_s1_busy),
        .o_accept (accept),
        .o_rd     (o_s2_rd),
        .o_fu     (o_s2_fu),
        .o_uop    (o_s2_uop),
        .o_trap   (o_s2_trap),
        .o_instr  (o_s2_instr),
        .o_opr_a  (o_s2_opr_a),
        .o_opr_b  (o_s2_opr_b),
        .o_opr_c  (o_s2_opr_c)
    );

endmodule

// File: dv/decode_checker.sv
`timescale 1ns/1ps

module decode_checker (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  i_flush,
    input  logic                  i_s2_busy,
    input  logic                  o_s1_busy,
    input  logic                  o_s2_valid,
    input  decode_pkg::reg_addr_t o_s2_rd,
    input  decode_pkg::fu_e       o_s2_fu,
    input  decode_pkg::uop_e      o_s2_uop,
    input  logic                  o_s2_trap,
    input  decode_pkg::word_t     o_s2_instr,
    input  decode_pkg::word_t     o_s2_opr_a,
    input  decode_pkg::word_t     o_s2_opr_b,
    input  decode_pkg::word_t     o_s2_opr_c
);
    import decode_pkg::*;

    // Entry layout {used c/b/a, trap, rd, fu, uop, instr, a, b, c}
    logic [144:0] exp_q [$];
    logic [144:0] exp;
    logic [144:0] got;
    logic [144:0] held;            // Snapshot while stalled
    logic         stalled;
    int           n_checks;
    int           n_err;

    assign got = {3'b111, o_s2_trap, o_s2_rd, o_s2_fu, o_s2_uop, o_s2_instr,
                  o_s2_opr_a, o_s2_opr_b, o_s2_opr_c};

    task automatic expect_push(input logic [144:0] e);
        exp_q.push_back(e);
    endtask

    task automatic check_field(input string name, input word_t e, input word_t g);
        n_checks++;
        if (e !== g) begin
            n_err++;
            $display("[FAIL] %s expected %08h got %08h", name, e, g);
        end
    endtask

    initial begin
        n_checks = 0;
        n_err    = 0;
        stalled  = 1'b0;
    end

    // Compare once per cycle on the falling edge
    always @(negedge g_clk) begin
        if (!g_resetn) begin
            stalled = 1'b0;
        end else begin
            if (stalled && got !== held) begin
                n_err++;
                $display("Stage outputs changed while the next stage was stalled");
            end
            check_field("o_s1_busy", word_t'(o_s2_valid && i_s2_busy), word_t'(o_s1_busy));
            if (o_s2_valid && !i_s2_busy) begin
                if (exp_q.size() == 0) begin
                    n_err++;
                    $display("Word %08h came out with nothing expected", o_s2_instr);
                end else begin
                    exp = exp_q.pop_front();
                    check_field("o_s2_instr", exp[127:96], o_s2_instr);
                    check_field("o_s2_fu", word_t'(exp[135:133]), word_t'(o_s2_fu));
                    check_field("o_s2_uop", word_t'(exp[132:128]), word_t'(o_s2_uop));
                    check_field("o_s2_rd", word_t'(exp[140:136]), word_t'(o_s2_rd));
                    check_field("o_s2_trap", word_t'(exp[141]), word_t'(o_s2_trap));
                    if (exp[142]) check_field("o_s2_opr_a", exp[95:64], o_s2_opr_a);
                    if (exp[143]) check_field("o_s2_opr_b", exp[63:32], o_s2_opr_b);
                    if (exp[144]) check_field("o_s2_opr_c", exp[31:0], o_s2_opr_c);
                end
            end else if (o_s2_valid && i_flush && exp_q.size() != 0) begin
                exp = exp_q.pop_front();    // Flushed word never leaves
            end
            stalled = o_s2_valid && i_s2_busy && !i_flush;
            held    = got;
        end
    end

endmodule

// File: dv/tb_decode.sv
`timescale 1ns/1ps

module tb_decode;
    import decode_pkg::*;

    localparam word_t       PC_RESET  = 32'h0000_1000;
    localparam int          RESET_CYC = 16;
    localparam int          TIMEOUT   = 300;
    localparam int          N_WORDS   = 40;
    localparam logic [31:0] SEED      = 32'hdbd14778;

    logic      g_clk;
    logic      g_resetn;
    logic      i_s1_valid;
    word_t     i_s1_data;
    logic      i_s1_error;
    logic      i_flush;
    word_t     i_rs1_rdata;
    word_t     i_rs2_rdata;
    logic      i_cf_req;
    word_t     i_cf_target;
    logic      i_cf_ack;
    logic      i_s2_busy;
    logic      o_s1_busy;
    reg_addr_t o_rs1_addr;
    reg_addr_t o_rs2_addr;
    logic      o_s2_valid;
    reg_addr_t o_s2_rd;
    fu_e       o_s2_fu;
    uop_e      o_s2_uop;
    logic      o_s2_trap;
    word_t     o_s2_opr_a;
    word_t     o_s2_opr_b;
    word_t     o_s2_opr_c;
    word_t     o_s2_instr;
    word_t     pc_track;
    int        stall_pct;
    int        err_base;
    logic [6:0] opc_list [9];

    decode_stage #(.PC_RESET_VALUE(PC_RESET)) u_dut (.*);

    decode_checker u_chk (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .i_flush    (i_flush),
        .i_s2_busy  (i_s2_busy),
        .o_s1_busy  (o_s1_busy),
        .o_s2_valid (o_s2_valid),
        .o_s2_rd    (o_s2_rd),
        .o_s2_fu    (o_s2_fu),
        .o_s2_uop   (o_s2_uop),
        .o_s2_trap  (o_s2_trap),
        .o_s2_instr (o_s2_instr),
        .o_s2_opr_a (o_s2_opr_a),
        .o_s2_opr_b (o_s2_opr_b),
        .o_s2_opr_c (o_s2_opr_c)
    );

    always #20 g_clk = ~g_clk;

    function automatic word_t reg_value(input reg_addr_t a);
        return (word_t'(a) * 32'h01010101) ^ 32'h5a5a0000;
    endfunction

    assign i_rs1_rdata = reg_value(o_rs1_addr);    // Register file model
    assign i_rs2_rdata = reg_value(o_rs2_addr);

    function automatic logic [4:0] alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return alt ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic logic [1:0] lsu_width(input logic [1:0] f);
        return (f == 2'd0) ? 2'b01 : (f == 2'd1) ? 2'b10 : 2'b11;
    endfunction

    function automatic logic [144:0] decode_ref(input word_t w, input logic err, input word_t pc);
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      r1;
        word_t      r2;
        word_t      ii;
        word_t      iu;
        logic [2:0] m;             // Used operands c/b/a
        logic       legal;
        reg_addr_t  rd;
        logic [2:0] fu;
        logic [4:0] uop;
        word_t      a;
        word_t      b;
        word_t      c;
        f3 = w[14:12];
        f7 = w[31:25];
        r1 = reg_value(w[19:15]);
        r2 = reg_value(w[24:20]);
        ii = {{20{w[31]}}, w[31:20]};
        iu = {w[31:12], 12'b0};
        {m, legal, fu, uop, a, b, c} = '0;
        rd = w[11:7];
        case (w[6:0])
            7'b0110011: begin
                legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                {fu, uop, m, a, b} = {FU_ALU, alu_op(f3, f7[5]), 3'b011, r1, r2};
            end
            7'b0010011: begin
                legal = (f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'd5);
                b = (f3[1:0] == 2'b01) ? word_t'(w[24:20]) : ii;
                {fu, uop, m, a} = {FU_ALU, alu_op(f3, f3 == 3'd5 && f7[5]), 3'b011, r1};
            end
            7'b0110111: {legal, fu, uop, m, a, b} = {1'b1, FU_ALU, ALU_OR, 3'b011, 32'd0, iu};
            7'b0010111: {legal, fu, uop, m, a, b} = {1'b1, FU_ALU, ALU_ADD, 3'b011, pc + iu, 32'd0};
            7'b0000011: begin
                legal = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
                {fu, uop, m, a, b} = {FU_LSU, 2'b10, lsu_width(f3[1:0]), !f3[2], 3'b011, r1, ii};
            end
            7'b0100011: begin
                legal = f3 <= 3'd2;
                b = {{20{w[31]}}, w[31:25], w[11:7]};
                {fu, uop, m, a, c, rd} = {FU_LSU, 2'b01, lsu_width(f3[1:0]), 1'b0, 3'b111,
                                          r1, r2, 5'd0};
            end
            7'b1100011: begin
                legal = f3 != 3'd2 && f3 != 3'd3;
                c = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                uop = (f3 == 3'd0) ? CFU_BEQ : (f3 == 3'd1) ? CFU_BNE : (f3 == 3'd4) ? CFU_BLT :
                      (f3 == 3'd5) ? CFU_BGE : (f3 == 3'd6) ? CFU_BLTU : CFU_BGEU;
                {fu, m, a, b, rd} = {FU_CFU, 3'b111, r1, r2, 5'd0};
            end
            7'b1101111: begin
                c = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                {legal, fu, uop, m, b} = {1'b1, FU_CFU, CFU_JALI, 3'b110, 32'd0};
            end
            7'b1100111: {legal, fu, uop, m, a, b} = {f3 == 3'd0, FU_CFU, CFU_JALR, 3'b011, r1, ii};
            default:    legal = 1'b0;
        endcase
        if (err || !legal) begin
            {fu, uop, m} = '0;
            rd = (err && legal) ? 5'd1 : 5'd2;    // Access fault only on a legal word
        end
        return {m, err || !legal, rd, fu, uop, w, a, b, c};
    endfunction

    // Expected entries and the tracked PC follow each accepting edge
    always @(negedge g_clk) begin
        if (g_resetn) begin
            if (i_s1_valid && !o_s1_busy && !i_flush) begin
                u_chk.expect_push(decode_ref(i_s1_data, i_s1_error, pc_track));
            end
            if (i_cf_req && i_cf_ack) begin
                pc_track = i_cf_target;
            end else if (i_s1_valid && !o_s1_busy && !i_flush) begin
                pc_track = pc_track + 32'd4;
            end
        end
    end

    function automatic word_t gen_word(input int lo, input int hi);
        word_t w;
        w      = $urandom;
        w[6:0] = opc_list[lo + ($urandom % (hi - lo + 1))];
        if ($urandom % 8 != 0) begin
            w[31:25] = ($urandom % 2) ? 7'h20 : 7'h00;    // Mostly legal funct7
        end
        return w;
    endfunction

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic send_word(input word_t w, input logic err, input logic redirect);
        int waited;
        waited = 0;
        @(posedge g_clk);
        i_s1_valid  <= 1'b1;
        i_s1_data   <= w;
        i_s1_error  <= err;
        i_cf_req    <= redirect;
        i_cf_ack    <= redirect;
        i_cf_target <= $urandom & 32'hffff_fffc;
        i_s2_busy   <= ($urandom % 100) < stall_pct;
        @(negedge g_clk);
        while (!(i_s1_valid && !o_s1_busy && !i_flush)) begin
            waited++;
            if (waited > TIMEOUT) timeout_fail("the fetch handshake");
            @(posedge g_clk);
            i_s2_busy <= ($urandom % 100) < stall_pct;
            i_cf_req  <= 1'b0;
            @(negedge g_clk);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge g_clk);
        i_s1_valid <= 1'b0;
        i_cf_req   <= 1'b0;
        i_cf_ack   <= 1'b0;
        @(negedge g_clk);
        while (o_s2_valid || u_chk.exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) timeout_fail("the stage to drain");
            @(posedge g_clk);
            i_s2_busy <= ($urandom % 100) < stall_pct;
            @(negedge g_clk);
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %-26s %s", name, (u_chk.n_err == err_base) ? "ok" : "had errors");
        err_base = u_chk.n_err;
    endtask

    initial begin
        void'($urandom(SEED));
        opc_list = '{7'b0110011, 7'b0010011, 7'b0110111, 7'b0010111, 7'b0000011,
                     7'b0100011, 7'b1100011, 7'b1101111, 7'b1100111};
        {g_clk, g_resetn, i_s1_valid, i_s1_error, i_flush} = '0;
        {i_cf_req, i_cf_ack, i_s2_busy} = '0;
        i_s1_data   = 32'h0000_0013;
        i_cf_target = '0;
        pc_track    = PC_RESET;
        stall_pct   = 0;
        err_base    = 0;
        repeat (RESET_CYC) @(posedge g_clk);
        g_resetn <= 1'b1;

        repeat (N_WORDS) send_word(gen_word(0, 3), 1'b0, 1'b0);
        drain();
        report_test("alu, lui and auipc");
        repeat (N_WORDS) send_word(gen_word(4, 5), 1'b0, 1'b0);
        drain();
        report_test("loads and stores");
        repeat (N_WORDS) send_word(gen_word(6, 8), 1'b0, ($urandom % 5) == 0);
        drain();
        report_test("branches and redirects");
        repeat (N_WORDS) send_word($urandom, ($urandom % 4) == 0, 1'b0);
        repeat (N_WORDS / 2) send_word(gen_word(0, 8), 1'b1, 1'b0);    // Faults on decodable words
        drain();
        report_test("illegal words and faults");
        stall_pct = 50;
        repeat (N_WORDS) send_word(gen_word(0, 8), 1'b0, 1'b0);
        drain();
        stall_pct = 0;
        report_test("back-pressure");
        repeat (4) begin
            stall_pct = 100;
            send_word(gen_word(0, 8), 1'b0, 1'b0);    // Held under stall
            @(posedge g_clk);
            i_s1_valid <= 1'b0;
            i_flush    <= 1'b1;
            @(posedge g_clk);
            i_flush   <= 1'b0;
            stall_pct = 0;
            repeat (2) send_word(gen_word(0, 8), 1'b0, 1'b0);
            drain();
        end
        report_test("flush");

        $display("Checks %0d, errors %0d", u_chk.n_checks, u_chk.n_err);
        if (u_chk.n_err == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
common/decode_pkg.sv
decode/instr_classifier.sv
decode/imm_builder.sv
decode/operand_select.sv
logic/stage_register.sv
decode/decode_stage.sv
dv/decode_checker.sv
dv/tb_decode.sv
